// File: verilog/video_config.svh
`ifndef VIDEO_CONFIG_SVH
`define VIDEO_CONFIG_SVH

// active frame geometry.
`define VIDEO_H_ACT 1280
`define VIDEO_V_ACT 720

// pipeline depth of mul_8_8.
`define VIDEO_MUL_LAT 3

// gray is (r*38 + g*75 + b*15) >> 7 with weights summing to 128.
`define VIDEO_COEF_R 8'd38
`define VIDEO_COEF_G 8'd75
`define VIDEO_COEF_B 8'd15

`endif

// File: verilog/video_pkg.sv
`include "video_config.svh"

package video_pkg;

    // coordinate widths follow the active area.
    localparam int x_w = $clog2(`VIDEO_H_ACT);
    localparam int y_w = $clog2(`VIDEO_V_ACT);

    // one pixel with its timing and position.
    // field order matches the pixel pack used across the video blocks.
    typedef struct packed {
        logic           hsync;
        logic           vsync;
        logic           de;
        logic [7:0]     r;
        logic [7:0]     g;
        logic [7:0]     b;
        logic [x_w-1:0] x;
        logic [y_w-1:0] y;
    } pixel_t;

    localparam int pix_w = $bits(pixel_t); // flat width for delay lines.

endpackage : video_pkg

// File: verilog/delay_line.sv
`timescale 1ns/1ps

module delay_line #(
    parameter int DELAY = 1,
    parameter int WIDTH = 8
) (
    input  logic             clk,
    input  logic             arst_n,
    input  logic [WIDTH-1:0] in_data,
    output logic [WIDTH-1:0] out_data
);

    logic [WIDTH-1:0] taps [DELAY];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < DELAY; i++) begin
                taps[i] <= '0;
            end
        end else begin
            taps[0] <= in_data;
            for (int i = 1; i < DELAY; i++) begin
                taps[i] <= taps[i-1]; // shift one stage.
            end
        end
    end

    assign out_data = taps[DELAY-1];

endmodule : delay_line

// File: verilog/mul_8_8.sv
`timescale 1ns/1ps

module mul_8_8 (
    input  logic        clk,
    input  logic        arst_n,
    input  logic [7:0]  a,
    input  logic [7:0]  b,
    output logic [15:0] p
);

    logic [7:0]  a_q;
    logic [7:0]  b_q;
    logic [11:0] pp_lo; // a[3:0] * b.
    logic [11:0] pp_hi; // a[7:4] * b.

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            a_q   <= '0;
            b_q   <= '0;
            pp_lo <= '0;
            pp_hi <= '0;
            p     <= '0;
        end else begin
            a_q   <= a;
            b_q   <= b;
            pp_lo <= a_q[3:0] * b_q;
            pp_hi <= a_q[7:4] * b_q;
            // recombine the nibble products.
            p     <= {pp_hi, 4'b0000} + {4'b0000, pp_lo};
        end
    end

endmodule : mul_8_8

// File: verilog/pixel_locator.sv
`timescale 1ns/1ps

module pixel_locator (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              hsync,
    input  logic              vsync,
    input  logic              de,
    input  logic [7:0]        r,
    input  logic [7:0]        g,
    input  logic [7:0]        b,
    output video_pkg::pixel_t pix
);

    logic                      de_q;
    logic                      de_fall;
    logic [video_pkg::x_w-1:0] x_cnt; // position of the next de pixel.
    logic [video_pkg::y_w-1:0] y_cnt;

    assign de_fall = de_q & ~de; // end of an active line.

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            de_q  <= 1'b0;
            x_cnt <= '0;
            y_cnt <= '0;
        end else begin
            de_q <= de;

            // x runs along the line and drops back once de goes low.
            if (de) begin
                x_cnt <= x_cnt + 1'b1;
            end else begin
                x_cnt <= '0;
            end

            // vsync wins over a line end.
            if (vsync) begin
                y_cnt <= '0;
            end else if (de_fall) begin
                y_cnt <= y_cnt + 1'b1;
            end
        end
    end

    // colour, syncs and position leave together.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pix <= '0;
        end else begin
            pix.hsync <= hsync;
            pix.vsync <= vsync;
            pix.de    <= de;
            pix.r     <= r;
            pix.g     <= g;
            pix.b     <= b;
            pix.x     <= x_cnt;
            pix.y     <= y_cnt;
        end
    end

endmodule : pixel_locator

// File: verilog/gray_convert.sv
`timescale 1ns/1ps

`include "video_config.svh"

module gray_convert (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              en,
    input  video_pkg::pixel_t pix_in,
    output video_pkg::pixel_t pix_out
);

    logic [15:0]       prod_r;
    logic [15:0]       prod_g;
    logic [15:0]       prod_b;
    logic [15:0]       prod_sum;
    logic [7:0]        gray_q;
    video_pkg::pixel_t pix_d;

    // one multiplier lane per channel.
    mul_8_8 u_mul_r (
        .clk   (clk          ),
        .arst_n(arst_n       ),
        .a     (pix_in.r     ),
        .b     (`VIDEO_COEF_R),
        .p     (prod_r       )
    );

    mul_8_8 u_mul_g (
        .clk   (clk          ),
        .arst_n(arst_n       ),
        .a     (pix_in.g     ),
        .b     (`VIDEO_COEF_G),
        .p     (prod_g       )
    );

    mul_8_8 u_mul_b (
        .clk   (clk          ),
        .arst_n(arst_n       ),
        .a     (pix_in.b     ),
        .b     (`VIDEO_COEF_B),
        .p     (prod_b       )
    );

    // peaks at 128 * 255, so 16 bits hold it.
    assign prod_sum = prod_r + prod_g + prod_b;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            gray_q <= '0;
        end else begin
            gray_q <= prod_sum[14:7]; // divide by 128.
        end
    end

    // multiplier depth plus the gray register.
    delay_line #(
        .DELAY(`VIDEO_MUL_LAT + 1),
        .WIDTH(video_pkg::pix_w  )
    ) u_bypass_delay (
        .clk     (clk   ),
        .arst_n  (arst_n),
        .in_data (pix_in),
        .out_data(pix_d )
    );

    // en picks gray or the original colour at the output.
    always_comb begin
        pix_out = pix_d;
        if (en) begin
            pix_out.r = gray_q;
            pix_out.g = gray_q;
            pix_out.b = gray_q;
        end
    end

endmodule : gray_convert

// File: verilog/video_pipe_top.sv
`timescale 1ns/1ps

module video_pipe_top (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              en,
    input  logic              hsync,
    input  logic              vsync,
    input  logic              de,
    input  logic [7:0]        r,
    input  logic [7:0]        g,
    input  logic [7:0]        b,
    output video_pkg::pixel_t pix_out
);

    video_pkg::pixel_t pix_loc; // positioned pixel into the gray stage.

    pixel_locator u_pixel_locator (
        .clk   (clk    ),
        .arst_n(arst_n ),
        .hsync (hsync  ),
        .vsync (vsync  ),
        .de    (de     ),
        .r     (r      ),
        .g     (g      ),
        .b     (b      ),
        .pix   (pix_loc)
    );

    gray_convert u_gray_convert (
        .clk    (clk    ),
        .arst_n (arst_n ),
        .en     (en     ),
        .pix_in (pix_loc),
        .pix_out(pix_out)
    );

endmodule : video_pipe_top

// File: verif/video_pipe_assertions.sv
`timescale 1ns/1ps

module video_pipe_assertions (
    input logic              clk,
    input logic              arst_n,
    input logic              en,
    input logic              hsync,
    input logic              vsync,
    input logic              de,
    input logic [7:0]        r,
    input logic [7:0]        g,
    input logic [7:0]        b,
    input video_pkg::pixel_t pix_out
);

    // raw pixel as it enters the top level.
    typedef struct packed {
        logic       hsync;
        logic       vsync;
        logic       de;
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } raw_t;

    localparam logic [video_pkg::x_w-1:0] x_step = 1;
    localparam logic [video_pkg::y_w-1:0] y_step = 1;

    raw_t                      raw_in;
    raw_t                      hist [5]; // five cycles of input history.
    raw_t                      exp_raw;
    logic [7:0]                exp_gray;
    logic [2:0]                rst_cnt;  // cycles since reset release.
    logic                      prev_de;
    logic [video_pkg::x_w-1:0] prev_x;
    logic [video_pkg::y_w-1:0] line_cnt;
    int unsigned               fail_cnt = 0;

    // weighted sum with weights 38, 75 and 15, then drop 7 bits.
    function automatic logic [7:0] gray_of(input raw_t px);
        logic [15:0] sum;
        sum = 16'd38 * px.r + 16'd75 * px.g + 16'd15 * px.b;
        return sum[14:7];
    endfunction

    assign raw_in   = {hsync, vsync, de, r, g, b};
    assign exp_raw  = hist[4];
    assign exp_gray = gray_of(exp_raw);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 5; i++) begin
                hist[i] <= '0;
            end
            rst_cnt  <= '0;
            prev_de  <= 1'b0;
            prev_x   <= '0;
            line_cnt <= '0;
        end else begin
            hist[0] <= raw_in;
            for (int i = 1; i < 5; i++) begin
                hist[i] <= hist[i-1];
            end
            if (rst_cnt != 3'd7) begin
                rst_cnt <= rst_cnt + 3'd1;
            end
            prev_de <= pix_out.de;
            if (pix_out.de) begin
                prev_x <= pix_out.x;
            end
            // lines seen at the output since the last vsync.
            if (pix_out.vsync) begin
                line_cnt <= '0;
            end else if (prev_de && !pix_out.de) begin
                line_cnt <= line_cnt + y_step;
            end
        end
    end

    a_reset_idle: assert property (@(posedge clk)
        (!arst_n || rst_cnt < 3'd5) |->
            {pix_out.hsync, pix_out.vsync, pix_out.de} == 3'b000)
        else begin
            fail_cnt++;
            $error("MISMATCH pix_out.syncs: got %h expected 0",
                $sampled({pix_out.hsync, pix_out.vsync, pix_out.de}));
        end

    a_sync_delay: assert property (@(posedge clk) disable iff (!arst_n)
        {pix_out.hsync, pix_out.vsync, pix_out.de} ==
            {exp_raw.hsync, exp_raw.vsync, exp_raw.de})
        else begin
            fail_cnt++;
            $error("MISMATCH pix_out.syncs: got %h expected %h",
                $sampled({pix_out.hsync, pix_out.vsync, pix_out.de}),
                $sampled({exp_raw.hsync, exp_raw.vsync, exp_raw.de}));
        end

    // en is applied at the output, so the current level decides.
    a_gray_on: assert property (@(posedge clk) disable iff (!arst_n)
        en |-> {pix_out.r, pix_out.g, pix_out.b} == {3{exp_gray}})
        else begin
            fail_cnt++;
            $error("MISMATCH pix_out.rgb: got %h expected %h",
                $sampled({pix_out.r, pix_out.g, pix_out.b}), $sampled({3{exp_gray}}));
        end

    a_white_stays: assert property (@(posedge clk) disable iff (!arst_n)
        (en && {exp_raw.r, exp_raw.g, exp_raw.b} == 24'hffffff) |-> pix_out.r == 8'hff)
        else begin
            fail_cnt++;
            $error("MISMATCH pix_out.r: got %h expected ff", $sampled(pix_out.r));
        end

    a_colour_bypass: assert property (@(posedge clk) disable iff (!arst_n)
        !en |-> {pix_out.r, pix_out.g, pix_out.b} == {exp_raw.r, exp_raw.g, exp_raw.b})
        else begin
            fail_cnt++;
            $error("MISMATCH pix_out.rgb: got %h expected %h",
                $sampled({pix_out.r, pix_out.g, pix_out.b}),
                $sampled({exp_raw.r, exp_raw.g, exp_raw.b}));
        end

    a_x_first: assert property (@(posedge clk) disable iff (!arst_n)
        (pix_out.de && !prev_de) |-> pix_out.x == '0)
        else begin
            fail_cnt++;
            $error("MISMATCH pix_out.x: got %h expected 0", $sampled(pix_out.x));
        end

    a_x_next: assert property (@(posedge clk) disable iff (!arst_n)
        (pix_out.de && prev_de) |-> pix_out.x == prev_x + x_step)
        else begin
            fail_cnt++;
            $error("MISMATCH pix_out.x: got %h expected %h",
                $sampled(pix_out.x), $sampled(prev_x + x_step));
        end

    a_y_line: assert property (@(posedge clk) disable iff (!arst_n)
        pix_out.de |-> pix_out.y == line_cnt)
        else begin
            fail_cnt++;
            $error("MISMATCH pix_out.y: got %h expected %h",
                $sampled(pix_out.y), $sampled(line_cnt));
        end

endmodule : video_pipe_assertions

// File: verif/tb_video_pipe.sv
`timescale 1ns/1ps

module tb_video_pipe;

    localparam int seed           = 34403;
    localparam int h_act          = 16;
    localparam int h_blank        = 6;
    localparam int hs_start       = 2; // hsync sits inside the blank.
    localparam int hs_len         = 2;
    localparam int v_act          = 6;
    localparam int v_blank        = 2;
    localparam int frames         = 3;
    localparam int line_len       = h_act + h_blank;
    localparam int frame_len      = line_len * (v_act + v_blank);
    localparam int timeout_cycles = 2 * frames * frame_len;

    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } rgb_t;

    logic              clk;
    logic              arst_n;
    logic              en;
    logic              hsync;
    logic              vsync;
    logic              de;
    logic [7:0]        r;
    logic [7:0]        g;
    logic [7:0]        b;
    video_pkg::pixel_t pix_out;

    int cycle_cnt = 0;
    int burst_left = 0;
    int burst_mode = 2;

    video_pipe_top i_dut (
        .clk    (clk    ),
        .arst_n (arst_n ),
        .en     (en     ),
        .hsync  (hsync  ),
        .vsync  (vsync  ),
        .de     (de     ),
        .r      (r      ),
        .g      (g      ),
        .b      (b      ),
        .pix_out(pix_out)
    );

    bind video_pipe_top video_pipe_assertions i_checks (
        .clk    (clk    ),
        .arst_n (arst_n ),
        .en     (en     ),
        .hsync  (hsync  ),
        .vsync  (vsync  ),
        .de     (de     ),
        .r      (r      ),
        .g      (g      ),
        .b      (b      ),
        .pix_out(pix_out)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= timeout_cycles) begin
            $display("timeout: pipeline did not finish");
            $display("Test failed");
            $fatal(1, "run stopped after %0d cycles", cycle_cnt);
        end
    end

    always @(posedge clk) begin
        if (i_dut.i_checks.fail_cnt != 0) begin
            $display("Test failed");
            $fatal(1, "assertion failure in the pixel pipeline");
        end
    end

    task automatic start_burst(input int mode);
        burst_mode = mode;
        burst_left = 5;
    endtask

    // 0 is black, 1 is white, anything else random.
    task automatic pick_colour(output rgb_t c);
        if (burst_left == 0) begin
            burst_mode = int'($urandom_range(0, 5));
            burst_left = int'($urandom_range(2, 6));
        end
        burst_left--;
        case (burst_mode)
            0: c = '0;
            1: c = '1;
            default: begin
                c.r = 8'($urandom);
                c.g = 8'($urandom);
                c.b = 8'($urandom);
            end
        endcase
    endtask

    task automatic drive_pixel(input logic hs, input logic vs, input logic d);
        rgb_t c;
        c = '0;
        if (d) begin
            pick_colour(c);
        end
        @(posedge clk);
        hsync <= hs;
        vsync <= vs;
        de    <= d;
        r     <= c.r;
        g     <= c.g;
        b     <= c.b;
        if ($urandom_range(0, 9) == 0) begin
            en <= ~en; // may land mid-line.
        end
    endtask

    task automatic drive_line(input int line_idx, input logic vs_line, input logic active);
        int pos;
        if (active && line_idx == 0) begin
            start_burst(1);
        end else if (active && line_idx == 1) begin
            start_burst(0);
        end
        for (pos = 0; pos < line_len; pos++) begin
            if (pos < h_act) begin
                drive_pixel(1'b0, vs_line, active);
            end else begin
                drive_pixel(pos >= h_act + hs_start && pos < h_act + hs_start + hs_len,
                    vs_line, 1'b0);
            end
        end
    endtask

    task automatic drive_frame();
        int line;
        for (line = 0; line < v_blank; line++) begin
            drive_line(0, line == 0, 1'b0); // vsync on the first blank line.
        end
        for (line = 0; line < v_act; line++) begin
            drive_line(line, 1'b0, 1'b1);
        end
    endtask

    initial begin
        void'($urandom(seed));
        arst_n = 1'b0;
        en     = 1'b1;
        hsync  = 1'b0;
        vsync  = 1'b0;
        de     = 1'b0;
        r      = '0;
        g      = '0;
        b      = '0;
        repeat (4) @(posedge clk);
        arst_n <= 1'b1;
        repeat (8) drive_pixel(1'b0, 1'b0, 1'b0);
        for (int f = 0; f < frames; f++) begin
            drive_frame();
        end
        repeat (8) drive_pixel(1'b0, 1'b0, 1'b0); // drain the pipe.
        @(negedge clk);
        if (i_dut.i_checks.fail_cnt == 0) begin
            $display("Test passed");
            $finish;
        end else begin
            $display("Test failed");
            $fatal(1, "assertion failure in the pixel pipeline");
        end
    end

endmodule : tb_video_pipe

// File: filelist.f
+incdir+verilog
verilog/video_pkg.sv
verilog/delay_line.sv
verilog/mul_8_8.sv
verilog/pixel_locator.sv
verilog/gray_convert.sv
verilog/video_pipe_top.sv
verif/video_pipe_assertions.sv
verif/tb_video_pipe.sv

// File: run_sim.sh
#!/usr/bin/env bash

cd "$(dirname "$0")" || exit 1

top=tb_video_pipe
log=sim.log

# build with assertions and timing support.
verilator --binary --timing --assert -Wno-fatal \
    --top-module "$top" -f filelist.f -o "sim_$top"
build_status=$?
if [ "$build_status" -ne 0 ]; then
    echo "verilator build failed with status $build_status"
    exit 1
fi

# let the testbench see every assertion failure before it stops.
./obj_dir/"sim_$top" +verilator+error+limit+1000 > "$log" 2>&1
run_status=$?
cat "$log"

if grep -q "Test failed" "$log"; then
    echo "simulation reported a failure, see $log"
    exit 1
fi

if [ "$run_status" -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

if ! grep -q "Test passed" "$log"; then
    echo "simulation ended without a result, see $log"
    exit 1
fi

echo "simulation passed"
exit 0
